// ==== design/csa_frame_pkg.sv ====
package csa_frame_pkg;

	////////////////////////////////////////
	// stream types
	////////////////////////////////////////

	typedef logic [7:0] byte_t;
	// bit 8 is the sync tag
	typedef logic [8:0] tagged_byte_t;
	typedef logic [63:0] cw_t;
	typedef logic [7:0] frame_idx_t;

	////////////////////////////////////////
	// frame layout
	////////////////////////////////////////

	// 19 prefix bytes + one 188 byte ts packet
	localparam int FRAME_LEN = 207;
	localparam int PREFIX_LEN = 19;
	localparam int TS_LEN = 188;
	localparam int TS_HDR_LEN = 4;
	localparam int TS_PAYLOAD_LEN = 184;

	// prefix positions
	localparam frame_idx_t SCRAM_POS = 8'd1;
	localparam frame_idx_t CW_FIRST = 8'd2;
	localparam int CW_BYTES = 8;
	localparam frame_idx_t DESC_FIRST = 8'd10;

	localparam byte_t TS_SYNC = 8'h47;
	// longer adaptation fields leave nothing worth scrambling
	localparam byte_t ADAPT_MAX_SCRAM = 8'd175;

endpackage

// ==== design/csa_frame_top.sv ====
`timescale 1ns/100ps

module csa_frame_top
	import csa_frame_pkg::*;
#(
	parameter int FIFO_DEPTH = 512,
	parameter int PFULL_LEVEL = FRAME_LEN
)
(
	input  logic         clk,
	input  logic         rst,
	input  logic         in_valid,
	input  byte_t        in_data,
	output logic         out_valid,
	output tagged_byte_t out_data,
	output logic         out_scram,
	output logic         cw_valid,
	output cw_t          cw
);

	// fifo write side
	logic wr_en;
	tagged_byte_t wr_data;

	// fifo read side
	logic rd_en;
	tagged_byte_t fifo_data;
	logic empty;
	logic prog_full;

	// broadcast of the byte now valid
	logic rd_data_valid;
	frame_idx_t byte_idx;
	logic scram_flag;
	logic payload_scram;

	frame_tagger u_tagger
	(
		.clk      (clk),
		.rst      (rst),
		.in_valid (in_valid),
		.in_data  (in_data),
		.wr_en    (wr_en),
		.wr_data  (wr_data)
	);

	tagged_fifo #(
		.FIFO_DEPTH  (FIFO_DEPTH),
		.PFULL_LEVEL (PFULL_LEVEL)
	) u_fifo
	(
		.clk       (clk),
		.rst       (rst),
		.wr_en     (wr_en),
		.wr_data   (wr_data),
		.rd_en     (rd_en),
		.rd_data   (fifo_data),
		.empty     (empty),
		.prog_full (prog_full)
	);

	packet_sequencer u_seq
	(
		.clk           (clk),
		.rst           (rst),
		.prog_full     (prog_full),
		.empty         (empty),
		.rd_en         (rd_en),
		.rd_data       (fifo_data),
		.rd_data_valid (rd_data_valid),
		.byte_idx      (byte_idx),
		.payload_scram (payload_scram),
		.out_valid     (out_valid),
		.out_data      (out_data),
		.out_scram     (out_scram)
	);

	cw_extract u_cw
	(
		.clk           (clk),
		.rst           (rst),
		.rd_data_valid (rd_data_valid),
		.rd_data       (fifo_data),
		.byte_idx      (byte_idx),
		.scram_flag    (scram_flag),
		.cw            (cw),
		.cw_valid      (cw_valid)
	);

	ts_header_parser u_hdr
	(
		.clk           (clk),
		.rst           (rst),
		.rd_data_valid (rd_data_valid),
		.rd_data       (fifo_data),
		.byte_idx      (byte_idx),
		.scram_flag    (scram_flag),
		.payload_scram (payload_scram)
	);

endmodule

// ==== design/csa_seq_pkg.sv ====
package csa_seq_pkg;

	import csa_frame_pkg::*;

	// read phases of one frame
	typedef enum logic [1:0]
	{
		IDLE,
		SEND_PREFIX,
		SEND_TS_HEADER,
		SEND_PAYLOAD
	} seq_state_t;

	////////////////////////////////////////
	// phase boundaries by frame position
	////////////////////////////////////////

	localparam frame_idx_t PREFIX_LAST_IDX = frame_idx_t'(FRAME_LEN - TS_LEN - 1);
	localparam frame_idx_t PAYLOAD_FIRST_IDX = frame_idx_t'(FRAME_LEN - TS_LEN + TS_HDR_LEN);
	// fourth ts header byte, holds adaptation_field_control
	localparam frame_idx_t HDR_LAST_IDX = frame_idx_t'(PAYLOAD_FIRST_IDX - 1);
	localparam frame_idx_t LAST_IDX = frame_idx_t'(PAYLOAD_FIRST_IDX + TS_PAYLOAD_LEN - 1);

endpackage

// ==== design/cw_extract.sv ====
`timescale 1ns/100ps

module cw_extract
	import csa_frame_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	input  logic         rd_data_valid,
	input  tagged_byte_t rd_data,
	input  frame_idx_t   byte_idx,
	output logic         scram_flag,
	output cw_t          cw,
	output logic         cw_valid
);

	localparam frame_idx_t CW_LAST_IDX = frame_idx_t'(CW_FIRST + CW_BYTES - 1);

	logic cw_byte;

	assign cw_byte = rd_data_valid && (byte_idx >= CW_FIRST) && (byte_idx <= CW_LAST_IDX);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			scram_flag <= 1'b0;
			cw_valid <= 1'b0;
		end
		else
		begin
			cw_valid <= rd_data_valid && (byte_idx == CW_LAST_IDX);
			if (rd_data_valid && (byte_idx == SCRAM_POS))
				scram_flag <= rd_data[0];
		end
	end

	// msb first, so shift in from the bottom
	always_ff @(posedge clk)
	begin
		if (cw_byte)
			cw <= {cw[$bits(cw_t)-9:0], rd_data[7:0]};
	end

endmodule

// ==== design/frame_tagger.sv ====
`timescale 1ns/100ps

module frame_tagger
	import csa_frame_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	input  logic         in_valid,
	input  byte_t        in_data,
	output logic         wr_en,
	output tagged_byte_t wr_data
);

	// position of the incoming byte inside its frame
	frame_idx_t pos;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pos <= '0;
			wr_en <= 1'b0;
		end
		else
		begin
			wr_en <= in_valid;
			if (in_valid)
			begin
				if (pos == frame_idx_t'(FRAME_LEN - 1))
					pos <= '0;
				else
					pos <= pos + 1'b1;
			end
		end
	end

	// tag the prefix sync and the ts sync
	always_ff @(posedge clk)
	begin
		if (in_valid)
			wr_data <= {(pos == '0) || (pos == frame_idx_t'(PREFIX_LEN)), in_data};
	end

	a_ts_sync: assert property (@(posedge clk) disable iff (rst)
		in_valid && (pos == frame_idx_t'(PREFIX_LEN)) |-> in_data == TS_SYNC);

endmodule

// ==== design/packet_sequencer.sv ====
`timescale 1ns/100ps

module packet_sequencer
	import csa_frame_pkg::*;
	import csa_seq_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	input  logic         prog_full,
	input  logic         empty,
	output logic         rd_en,
	input  tagged_byte_t rd_data,
	output logic         rd_data_valid,
	output frame_idx_t   byte_idx,
	input  logic         payload_scram,
	output logic         out_valid,
	output tagged_byte_t out_data,
	output logic         out_scram
);

	// the held sync byte goes out in place of the last dropped byte
	localparam frame_idx_t SYNC_EMIT_IDX = frame_idx_t'(DESC_FIRST - 1);

	seq_state_t state;
	frame_idx_t rd_cnt;
	tagged_byte_t sync_hold;

	////////////////////////////////////////
	// read side FSM
	////////////////////////////////////////

	// one read per cycle while a frame is in flight
	assign rd_en = (state != IDLE);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= IDLE;
			rd_cnt <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					rd_cnt <= '0;
					if (prog_full && !empty)
						state <= SEND_PREFIX;
				end
				SEND_PREFIX:
				begin
					rd_cnt <= rd_cnt + 1'b1;
					if (rd_cnt == PREFIX_LAST_IDX)
						state <= SEND_TS_HEADER;
				end
				SEND_TS_HEADER:
				begin
					rd_cnt <= rd_cnt + 1'b1;
					if (rd_cnt == HDR_LAST_IDX)
						state <= SEND_PAYLOAD;
				end
				SEND_PAYLOAD:
				begin
					rd_cnt <= rd_cnt + 1'b1;
					// last byte of the ts packet
					if (rd_cnt == LAST_IDX)
						state <= IDLE;
				end
				default:
				begin
					state <= IDLE;
				end
			endcase
		end
	end

	// fifo data lands one cycle after the read
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			rd_data_valid <= 1'b0;
			byte_idx <= '0;
		end
		else
		begin
			rd_data_valid <= rd_en;
			byte_idx <= rd_cnt;
		end
	end

	////////////////////////////////////////
	// output register
	////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			out_valid <= 1'b0;
			out_scram <= 1'b0;
		end
		else
		begin
			// prefix bytes 1..8 dropped, byte 9 slot carries the sync byte
			out_valid <= rd_data_valid && (byte_idx >= SYNC_EMIT_IDX);
			out_scram <= rd_data_valid && payload_scram;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rd_data_valid && (byte_idx == '0))
			sync_hold <= rd_data;
		if (byte_idx == SYNC_EMIT_IDX)
			out_data <= sync_hold;
		else
			out_data <= rd_data;
	end

	// frame alignment between tagger and read side
	a_frame_start: assert property (@(posedge clk) disable iff (rst)
		rd_data_valid && (byte_idx == '0) |-> rd_data[8]);

endmodule

// ==== design/tagged_fifo.sv ====
`timescale 1ns/100ps

module tagged_fifo
	import csa_frame_pkg::*;
#(
	parameter int FIFO_DEPTH = 512,
	parameter int PFULL_LEVEL = FRAME_LEN
)
(
	input  logic         clk,
	input  logic         rst,
	input  logic         wr_en,
	input  tagged_byte_t wr_data,
	input  logic         rd_en,
	output tagged_byte_t rd_data,
	output logic         empty,
	output logic         prog_full
);

	localparam int AW = $clog2(FIFO_DEPTH);
	localparam int CNTW = $clog2(FIFO_DEPTH + 1);

	tagged_byte_t mem [FIFO_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CNTW-1:0] count;
	logic [CNTW-1:0] count_next;
	logic full;

	if (PFULL_LEVEL < FRAME_LEN || PFULL_LEVEL > FIFO_DEPTH)
	begin : g_bad_level
		$error("tagged_fifo: PFULL_LEVEL must lie between FRAME_LEN and FIFO_DEPTH");
	end

	assign count_next = count + CNTW'(wr_en) - CNTW'(rd_en);
	assign empty = (count == '0);
	assign full = (count == CNTW'(FIFO_DEPTH));

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			prog_full <= 1'b0;
		end
		else
		begin
			count <= count_next;
			// flag follows the updated count
			prog_full <= (count_next >= CNTW'(PFULL_LEVEL));
			if (wr_en)
				wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
		end
	end

	// storage and read port
	always_ff @(posedge clk)
	begin
		if (wr_en)
			mem[wr_ptr] <= wr_data;
		if (rd_en)
			rd_data <= mem[rd_ptr];
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (rst) wr_en |-> !full);
	a_no_underflow: assert property (@(posedge clk) disable iff (rst) rd_en |-> !empty);

endmodule

// ==== design/ts_header_parser.sv ====
`timescale 1ns/100ps

module ts_header_parser
	import csa_frame_pkg::*;
	import csa_seq_pkg::*;
(
	input  logic         clk,
	input  logic         rst,
	input  logic         rd_data_valid,
	input  tagged_byte_t rd_data,
	input  frame_idx_t   byte_idx,
	input  logic         scram_flag,
	output logic         payload_scram
);

	// adaptation field present, in the fourth header byte
	localparam int ADAPT_BIT = 5;

	logic adapt_flag;
	byte_t adapt_len;
	// adaptation bytes still to come
	byte_t adapt_cnt;
	logic in_payload;
	logic past_adapt;
	logic len_ok;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			adapt_flag <= 1'b0;
			adapt_cnt <= '0;
		end
		else if (rd_data_valid)
		begin
			if (byte_idx == HDR_LAST_IDX)
			begin
				adapt_flag <= rd_data[ADAPT_BIT];
				adapt_cnt <= '0;
			end
			else if ((byte_idx == PAYLOAD_FIRST_IDX) && adapt_flag)
			begin
				adapt_cnt <= rd_data[7:0];
			end
			else if (adapt_cnt != '0)
			begin
				adapt_cnt <= adapt_cnt - 1'b1;
			end
		end
	end

	// length byte is the first payload byte
	always_ff @(posedge clk)
	begin
		if (rd_data_valid && adapt_flag && (byte_idx == PAYLOAD_FIRST_IDX))
			adapt_len <= rd_data[7:0];
	end

	////////////////////////////////////////
	// per byte scramble mark
	////////////////////////////////////////

	assign in_payload = (byte_idx >= PAYLOAD_FIRST_IDX);
	assign past_adapt = !adapt_flag || ((byte_idx != PAYLOAD_FIRST_IDX) && (adapt_cnt == '0));
	assign len_ok = !adapt_flag || (adapt_len <= ADAPT_MAX_SCRAM);
	assign payload_scram = scram_flag && in_payload && past_adapt && len_ok;

endmodule

// ==== project.f ====
design/csa_frame_pkg.sv
design/csa_seq_pkg.sv
design/frame_tagger.sv
design/tagged_fifo.sv
design/packet_sequencer.sv
design/cw_extract.sv
design/ts_header_parser.sv
design/csa_frame_top.sv
test/tb_csa_frame.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the csa framing testbench with verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_csa_frame -f project.f -o tb_csa_frame \
	&& ./obj_dir/tb_csa_frame | tee /dev/stderr | grep -F '*** PASSED ***' > /dev/null \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

// ==== test/csa_stimulus.txt ====
// columns: scramble flag, control word, adaptation field control, adaptation length,
// expected count of marked payload bytes (all hex, one frame per line)
0 0123456789abcdef 1 00 00
1 1122334455667788 1 00 b8
1 a5a5a5a55a5a5a5a 3 00 b7
1 0f1e2d3c4b5a6978 3 07 b0
1 8899aabbccddeeff 3 64 53
1 0000000000000001 3 af 08
1 8000000000000000 3 b0 00
1 13579bdf2468ace0 2 b7 00
0 fedcba9876543210 3 20 00
1 ffffffffffffffff 1 00 b8
1 0123012301230123 3 ae 09
1 3c3c3c3cc3c3c3c3 3 10 a7

// ==== test/tb_csa_frame.sv ====
`timescale 1ns/100ps

module tb_csa_frame
	import csa_frame_pkg::*;
();

	localparam int MAX_FRAMES = 32;
	localparam int STIM_COLS = 5;
	// sync byte, descriptors, ts header and payload
	localparam int OUT_LEN = 1 + FRAME_LEN - DESC_FIRST;
	localparam int PAYLOAD_OUT_FIRST = 1 + PREFIX_LEN - DESC_FIRST + TS_HDR_LEN;
	localparam int CYCLES_PER_FRAME = 300;
	localparam logic [15:0] LFSR_SEED = 16'd23448;
	localparam logic [15:0] LFSR_TAPS = 16'hB400;
	localparam byte_t PREFIX_SYNC = 8'hB8;

	logic clk;
	logic rst;
	logic in_valid;
	byte_t in_data;
	logic out_valid;
	tagged_byte_t out_data;
	logic out_scram;
	logic cw_valid;
	cw_t cw;

	logic [63:0] stim_mem [MAX_FRAMES * STIM_COLS];
	logic frame_flag [MAX_FRAMES];
	cw_t frame_cw [MAX_FRAMES];
	logic [1:0] frame_afc [MAX_FRAMES];
	byte_t frame_len [MAX_FRAMES];
	int frame_marks [MAX_FRAMES];
	byte_t frame_mem [MAX_FRAMES][FRAME_LEN];

	int num_frames;
	int errors;
	int failed_frames;
	int cw_count;
	int cycle_cnt;
	int cycle_limit;
	logic [15:0] lfsr;

	csa_frame_top u_dut
	(
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_data   (in_data),
		.out_valid (out_valid),
		.out_data  (out_data),
		.out_scram (out_scram),
		.cw_valid  (cw_valid),
		.cw        (cw)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////

	// galois lfsr, one step per bit taken
	function automatic byte_t random_byte();
		byte_t b;
		b = '0;
		for (int i = 0; i < 8; i++)
		begin
			b = {b[6:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
		end
		return b;
	endfunction

	task automatic load_stimulus();
		for (int i = 0; i < MAX_FRAMES * STIM_COLS; i++)
			stim_mem[i] = '1;
		$readmemh("test/csa_stimulus.txt", stim_mem);
		num_frames = 0;
		// flag column left at all ones means no more lines
		while (num_frames < MAX_FRAMES && stim_mem[num_frames * STIM_COLS] != '1)
		begin
			frame_flag[num_frames] = stim_mem[num_frames * STIM_COLS][0];
			frame_cw[num_frames] = stim_mem[num_frames * STIM_COLS + 1];
			frame_afc[num_frames] = stim_mem[num_frames * STIM_COLS + 2][1:0];
			frame_len[num_frames] = stim_mem[num_frames * STIM_COLS + 3][7:0];
			frame_marks[num_frames] = int'(stim_mem[num_frames * STIM_COLS + 4][7:0]);
			num_frames++;
		end
	endtask

	task automatic build_frames();
		byte_t b;
		for (int f = 0; f < num_frames; f++)
		begin
			frame_mem[f][0] = PREFIX_SYNC;
			b = random_byte();
			frame_mem[f][SCRAM_POS] = {b[7:1], frame_flag[f]};
			for (int k = 0; k < CW_BYTES; k++)
				frame_mem[f][CW_FIRST + k] = frame_cw[f][63 - 8 * k -: 8];
			for (int k = DESC_FIRST; k < PREFIX_LEN; k++)
				frame_mem[f][k] = random_byte();
			// afc in bits 5:4, continuity counter below
			frame_mem[f][PREFIX_LEN] = TS_SYNC;
			frame_mem[f][PREFIX_LEN + 1] = random_byte();
			frame_mem[f][PREFIX_LEN + 2] = random_byte();
			frame_mem[f][PREFIX_LEN + 3] = {2'b00, frame_afc[f], 4'(f)};
			for (int k = PREFIX_LEN + TS_HDR_LEN; k < FRAME_LEN; k++)
				frame_mem[f][k] = random_byte();
			// adaptation length sits in the first payload byte
			if (frame_afc[f][1])
				frame_mem[f][PREFIX_LEN + TS_HDR_LEN] = frame_len[f];
		end
	endtask

	// starts 2 ns after a rising edge
	task automatic drive_frames();
		for (int f = 0; f < num_frames; f++)
		begin
			for (int b = 0; b < FRAME_LEN; b++)
			begin
				in_valid = 1'b1;
				in_data = frame_mem[f][b];
				@(posedge clk);
				#2;
			end
			// short idle gap after every fourth frame
			if (f % 4 == 3)
			begin
				in_valid = 1'b0;
				in_data = '0;
				repeat (7)
				begin
					@(posedge clk);
					#2;
				end
			end
		end
		in_valid = 1'b0;
		in_data = '0;
	endtask

	////////////////////////////////////////
	// expected output
	////////////////////////////////////////

	function automatic tagged_byte_t expected_byte(input int f, input int n);
		int idx;
		if (n == 0)
			return {1'b1, frame_mem[f][0]};
		idx = n + DESC_FIRST - 1;
		return {idx == PREFIX_LEN, frame_mem[f][idx]};
	endfunction

	// payload past the adaptation field and its length byte, only if flagged
	function automatic logic expected_mark(input int f, input int n);
		int p;
		p = n - PAYLOAD_OUT_FIRST;
		if (n < PAYLOAD_OUT_FIRST || !frame_flag[f])
			return 1'b0;
		if (!frame_afc[f][1])
			return 1'b1;
		if (frame_len[f] > ADAPT_MAX_SCRAM)
			return 1'b0;
		return p > int'(frame_len[f]);
	endfunction

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	task automatic check_reset_outputs();
		@(negedge clk);
		assert (!out_valid && !cw_valid && !out_scram) else
		begin
			$display("outputs not low during reset at %0t", $time);
			errors++;
		end
	endtask

	task automatic check_frame(input int f);
		int n;
		int marks;
		int errs_before;
		tagged_byte_t exp_byte;
		logic exp_mark;
		n = 0;
		marks = 0;
		errs_before = errors;
		while (n < OUT_LEN)
		begin
			@(negedge clk);
			if (out_valid)
			begin
				exp_byte = expected_byte(f, n);
				exp_mark = expected_mark(f, n);
				assert (out_data == exp_byte) else
				begin
					$display("mismatch at %0t: frame %0d byte %0d out_data expected %h got %h",
						$time, f, n, exp_byte, out_data);
					errors++;
				end
				assert (out_scram == exp_mark) else
				begin
					$display("mismatch at %0t: frame %0d byte %0d out_scram expected %0b got %0b",
						$time, f, n, exp_mark, out_scram);
					errors++;
				end
				if (out_scram)
					marks++;
				n++;
			end
			else
			begin
				assert (!out_scram) else
				begin
					$display("out_scram set without out_valid at %0t", $time);
					errors++;
				end
			end
		end
		assert (marks == frame_marks[f]) else
		begin
			$display("mismatch at %0t: frame %0d marked payload bytes expected %0d got %0d",
				$time, f, frame_marks[f], marks);
			errors++;
		end
		assert (cw_count == f + 1) else
		begin
			$display("frame %0d ended after %0d control word strobes instead of %0d",
				f, cw_count, f + 1);
			errors++;
		end
		if (errors != errs_before)
			failed_frames++;
		$display("frame %0d: scramble %0d, afc %0d, adaptation length %0d, %0d marked, %s",
			f, frame_flag[f], frame_afc[f], frame_len[f], marks,
			(errors == errs_before) ? "ok" : "bad");
	endtask

	task automatic check_all_frames();
		for (int f = 0; f < num_frames; f++)
			check_frame(f);
	endtask

	// nothing more may come out once every frame is seen
	task automatic check_drained();
		repeat (20)
		begin
			@(negedge clk);
			assert (!out_valid && !cw_valid) else
			begin
				$display("extra output strobe after the last frame at %0t", $time);
				errors++;
			end
		end
		assert (cw_count == num_frames) else
		begin
			$display("mismatch at %0t: cw_valid count expected %0d got %0d",
				$time, num_frames, cw_count);
			errors++;
		end
	endtask

	always @(negedge clk)
	begin
		if (!rst && cw_valid)
		begin
			assert (cw_count < num_frames) else
			begin
				$display("control word strobe at %0t with no frame left", $time);
				errors++;
			end
			if (cw_count < num_frames)
			begin
				assert (cw == frame_cw[cw_count]) else
				begin
					$display("mismatch at %0t: cw expected %h got %h",
						$time, frame_cw[cw_count], cw);
					errors++;
				end
				assert (u_dut.u_cw.scram_flag == frame_flag[cw_count]) else
				begin
					$display("mismatch at %0t: scram_flag expected %0b got %0b",
						$time, frame_flag[cw_count], u_dut.u_cw.scram_flag);
					errors++;
				end
			end
			cw_count++;
		end
	end

	initial
	begin
		cycle_cnt = 0;
		@(posedge clk);
		while (cycle_cnt < cycle_limit)
		begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout after %0d cycles, output stream incomplete", cycle_cnt);
		$display("*** FAILED ***");
		$finish;
	end

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial
	begin
		rst = 1'b1;
		in_valid = 1'b0;
		in_data = '0;
		errors = 0;
		failed_frames = 0;
		cw_count = 0;
		lfsr = LFSR_SEED;
		load_stimulus();
		cycle_limit = CYCLES_PER_FRAME * num_frames;
		if (num_frames == 0)
		begin
			$display("no frames read from test/csa_stimulus.txt");
			errors++;
		end
		else
		begin
			build_frames();
			repeat (4) @(posedge clk);
			check_reset_outputs();
			@(posedge clk);
			#2;
			rst = 1'b0;
			fork
				drive_frames();
				check_all_frames();
			join
			check_drained();
		end
		$display("frames %0d, passed %0d, failed %0d, errors %0d",
			num_frames, num_frames - failed_frames, failed_frames, errors);
		if (errors == 0 && failed_frames == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule
